// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

    // Datapath widths
    typedef logic [31:0] instr_t;                     // Raw instruction word
    typedef logic [31:0] xlen_t;                      // Register value or result
    typedef logic [31:0] pc_t;                        // Instruction address
    typedef logic [4:0]  reg_idx_t;                   // Register index field
    typedef logic [3:0]  alu_op_t;                    // ALU operation code

    // Instruction field types
    typedef logic [6:0] opcode_t;                     // Major opcode incl. bits [1:0]
    typedef logic [2:0] funct3_t;                     // Minor opcode
    typedef logic [6:0] funct7_t;                     // Upper function bits

    // Supported major opcodes
    localparam opcode_t OPC_OP_IMM = 7'b0010011;      // Register-immediate ALU ops
    localparam opcode_t OPC_OP     = 7'b0110011;      // Register-register ALU ops
    localparam opcode_t OPC_LUI    = 7'b0110111;      // Load upper immediate
    localparam opcode_t OPC_AUIPC  = 7'b0010111;      // Add upper immediate to PC

    // funct3 values shared by OP and OP_IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;          // ADD, SUB, ADDI
    localparam funct3_t F3_SLL     = 3'b001;          // SLL, SLLI
    localparam funct3_t F3_SLT     = 3'b010;          // SLT, SLTI
    localparam funct3_t F3_SLTU    = 3'b011;          // SLTU, SLTIU
    localparam funct3_t F3_XOR     = 3'b100;          // XOR, XORI
    localparam funct3_t F3_SRL_SRA = 3'b101;          // Right shifts, split by funct7
    localparam funct3_t F3_OR      = 3'b110;          // OR, ORI
    localparam funct3_t F3_AND     = 3'b111;          // AND, ANDI

    // funct7 values
    localparam funct7_t F7_BASE = 7'b0000000;         // Normal form
    localparam funct7_t F7_ALT  = 7'b0100000;         // SUB and SRA/SRAI

    // ALU operation codes
    localparam alu_op_t ALU_ADD    = 4'd0;            // a + b
    localparam alu_op_t ALU_SUB    = 4'd1;            // a - b
    localparam alu_op_t ALU_SLL    = 4'd2;            // Logical left shift
    localparam alu_op_t ALU_SLT    = 4'd3;            // Signed less-than
    localparam alu_op_t ALU_SLTU   = 4'd4;            // Unsigned less-than
    localparam alu_op_t ALU_XOR    = 4'd5;            // Bitwise xor
    localparam alu_op_t ALU_SRL    = 4'd6;            // Logical right shift
    localparam alu_op_t ALU_SRA    = 4'd7;            // Arithmetic right shift
    localparam alu_op_t ALU_OR     = 4'd8;            // Bitwise or
    localparam alu_op_t ALU_AND    = 4'd9;            // Bitwise and
    localparam alu_op_t ALU_PASS_B = 4'd10;           // Second operand straight through

    // Codes 11 to 15 are unused and give zero in the ALU

endpackage

`default_nettype wire

// File: decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if;

    logic              valid;                         // One-cycle strobe per decoded word
    rv_pkg::alu_op_t   alu_op;                        // Operation for the ALU
    logic              pc_rs1_sel;                    // Operand A is pc, for AUIPC
    logic              imm_rs2_sel;                   // Operand B is the immediate
    rv_pkg::reg_idx_t  rs1;                           // First source register
    rv_pkg::reg_idx_t  rs2;                           // Second source register
    rv_pkg::reg_idx_t  rd;                            // Destination register
    rv_pkg::xlen_t     imm;                           // Fully extended immediate
    rv_pkg::pc_t       pc;                            // Address of this instruction

    modport decoder (
        output valid, alu_op, pc_rs1_sel, imm_rs2_sel,
        output rs1, rs2, rd, imm, pc
    );

    modport execute (
        input valid, alu_op, pc_rs1_sel, imm_rs2_sel,
        input rs1, rs2, rd, imm, pc
    );

endinterface

`default_nettype wire

// File: control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit #(
    parameter int NUM_REGS = 32                       // 32 for RV32I, 16 for RV32E
) (
    input  wire             clk,
    input  wire             rst,
    input  logic            instr_valid,              // Word strobe, no back-pressure
    input  rv_pkg::instr_t  instr,
    output logic            illegal,                  // Pulses instead of decoded.valid
    decode_if.decoder       decoded
);

    rv_pkg::opcode_t  opcode;
    rv_pkg::funct3_t  funct3;
    rv_pkg::funct7_t  funct7;
    rv_pkg::reg_idx_t rd_f, rs1_f, rs2_f;

    rv_pkg::alu_op_t  alu_op_d;
    logic             pc_rs1_sel_d, imm_rs2_sel_d;
    logic             uses_rs1, uses_rs2;
    logic             bad_d;                          // Word cannot be executed
    rv_pkg::xlen_t    imm_i, imm_u, imm_sh, imm_d;
    rv_pkg::pc_t      pc_cnt;                         // Running instruction address

    function automatic logic idx_bad(input rv_pkg::reg_idx_t idx);
        idx_bad = (int'(idx) >= NUM_REGS);            // Only reachable when NUM_REGS is 16
    endfunction

    assign opcode = instr[6:0];
    assign rd_f   = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1_f  = instr[19:15];
    assign rs2_f  = instr[24:20];
    assign funct7 = instr[31:25];

    assign imm_i  = {{20{instr[31]}}, instr[31:20]};  // Sign-extended I-type
    assign imm_u  = {instr[31:12], 12'b0};            // U-type, low bits zero
    assign imm_sh = {27'b0, instr[24:20]};            // Shift amount, unsigned

    always_comb begin
        alu_op_d      = rv_pkg::ALU_ADD;              // Safe defaults, nothing selected
        pc_rs1_sel_d  = 1'b0;
        imm_rs2_sel_d = 1'b0;
        uses_rs1      = 1'b0;
        uses_rs2      = 1'b0;
        imm_d         = '0;
        bad_d         = 1'b0;

        case (opcode)
            rv_pkg::OPC_OP_IMM, rv_pkg::OPC_OP: begin
                uses_rs1 = 1'b1;
                uses_rs2 = (opcode == rv_pkg::OPC_OP);
                imm_rs2_sel_d = (opcode == rv_pkg::OPC_OP_IMM);
                imm_d = imm_i;
                case (funct3)
                    rv_pkg::F3_ADD_SUB: alu_op_d = rv_pkg::ALU_ADD;
                    rv_pkg::F3_SLL:     alu_op_d = rv_pkg::ALU_SLL;
                    rv_pkg::F3_SLT:     alu_op_d = rv_pkg::ALU_SLT;
                    rv_pkg::F3_SLTU:    alu_op_d = rv_pkg::ALU_SLTU;
                    rv_pkg::F3_XOR:     alu_op_d = rv_pkg::ALU_XOR;
                    rv_pkg::F3_SRL_SRA: alu_op_d = rv_pkg::ALU_SRL;
                    rv_pkg::F3_OR:      alu_op_d = rv_pkg::ALU_OR;
                    default:            alu_op_d = rv_pkg::ALU_AND;
                endcase
                if (funct3 == rv_pkg::F3_SLL || funct3 == rv_pkg::F3_SRL_SRA) begin
                    imm_d = imm_sh;                   // funct7 bits are not part of shamt
                end
                // funct7 only matters where the I-type immediate does not cover it
                if (opcode == rv_pkg::OPC_OP || imm_d == imm_sh) begin
                    if (funct7 == rv_pkg::F7_ALT) begin
                        if (funct3 == rv_pkg::F3_SRL_SRA) begin
                            alu_op_d = rv_pkg::ALU_SRA;
                        end else if (funct3 == rv_pkg::F3_ADD_SUB &&
                                     opcode == rv_pkg::OPC_OP) begin
                            alu_op_d = rv_pkg::ALU_SUB;   // No SUBI form exists
                        end else begin
                            bad_d = 1'b1;
                        end
                    end else if (funct7 != rv_pkg::F7_BASE) begin
                        bad_d = 1'b1;
                    end
                end
            end
            rv_pkg::OPC_LUI: begin
                imm_rs2_sel_d = 1'b1;
                alu_op_d      = rv_pkg::ALU_PASS_B;
                imm_d         = imm_u;
            end
            rv_pkg::OPC_AUIPC: begin
                pc_rs1_sel_d  = 1'b1;                 // pc + upper immediate
                imm_rs2_sel_d = 1'b1;
                imm_d         = imm_u;
            end
            default: bad_d = 1'b1;                    // Loads, stores, branches and the rest
        endcase

        if (idx_bad(rd_f) || (uses_rs1 && idx_bad(rs1_f)) || (uses_rs2 && idx_bad(rs2_f))) begin
            bad_d = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decoded.valid <= 1'b0;
            illegal       <= 1'b0;
            pc_cnt        <= '0;
        end else begin
            decoded.valid <= instr_valid && !bad_d;
            illegal       <= instr_valid && bad_d;
            if (instr_valid && !bad_d) begin
                pc_cnt <= pc_cnt + 32'd4;             // Steps on accepted words only
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            decoded.alu_op      <= alu_op_d;
            decoded.pc_rs1_sel  <= pc_rs1_sel_d;
            decoded.imm_rs2_sel <= imm_rs2_sel_d;
            decoded.rs1         <= uses_rs1 ? rs1_f : '0;  // Unused sources park on x0
            decoded.rs2         <= uses_rs2 ? rs2_f : '0;
            decoded.rd          <= rd_f;
            decoded.imm         <= imm_d;
            decoded.pc          <= pc_cnt;            // Address before the increment
        end
    end

endmodule

`default_nettype wire

// File: register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file #(
    parameter int NUM_REGS = 32
) (
    input  wire               clk,
    input  wire               rst,
    input  rv_pkg::reg_idx_t  rs1,                    // Read address A
    input  rv_pkg::reg_idx_t  rs2,                    // Read address B
    output rv_pkg::xlen_t     rs1_data,
    output rv_pkg::xlen_t     rs2_data,
    input  logic              wr_en,
    input  rv_pkg::reg_idx_t  wr_rd,
    input  rv_pkg::xlen_t     wr_data
);

    localparam int IDX_W = $clog2(NUM_REGS);          // 5 for RV32I, 4 for RV32E

    rv_pkg::xlen_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;                        // Architectural state starts at zero
            end
        end else if (wr_en && wr_rd != '0) begin
            regs[wr_rd[IDX_W-1:0]] <= wr_data;        // x0 stays zero
        end
    end

    // Write-first bypass so a dependent read sees the value in flight
    always_comb begin
        if (rs1 == '0) begin
            rs1_data = '0;
        end else if (wr_en && wr_rd == rs1) begin
            rs1_data = wr_data;
        end else begin
            rs1_data = regs[rs1[IDX_W-1:0]];
        end

        if (rs2 == '0) begin
            rs2_data = '0;
        end else if (wr_en && wr_rd == rs2) begin
            rs2_data = wr_data;
        end else begin
            rs2_data = regs[rs2[IDX_W-1:0]];
        end
    end

endmodule

`default_nettype wire

// File: execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  wire               clk,
    input  wire               rst,
    decode_if.execute         decoded,
    output rv_pkg::reg_idx_t  rs1,                    // Register file read addresses
    output rv_pkg::reg_idx_t  rs2,
    input  rv_pkg::xlen_t     rs1_data,
    input  rv_pkg::xlen_t     rs2_data,
    output logic              wb_valid,               // Also the register file write enable
    output rv_pkg::reg_idx_t  wb_rd,
    output rv_pkg::xlen_t     wb_data
);

    rv_pkg::xlen_t op_a;
    rv_pkg::xlen_t op_b;
    rv_pkg::xlen_t alu_res;
    logic [4:0]    shamt;                             // Low 5 bits of operand B

    assign rs1 = decoded.rs1;
    assign rs2 = decoded.rs2;

    // Operand selection
    assign op_a  = decoded.pc_rs1_sel ? decoded.pc : rs1_data;      // pc only for AUIPC
    assign op_b  = decoded.imm_rs2_sel ? decoded.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (decoded.alu_op)
            rv_pkg::ALU_ADD: begin
                alu_res = op_a + op_b;
            end
            rv_pkg::ALU_SUB: begin
                alu_res = op_a - op_b;
            end
            rv_pkg::ALU_SLL: begin
                alu_res = op_a << shamt;
            end
            rv_pkg::ALU_SLT: begin
                alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            end
            rv_pkg::ALU_SLTU: begin
                alu_res = {31'b0, op_a < op_b};       // Immediate already sign-extended
            end
            rv_pkg::ALU_XOR: begin
                alu_res = op_a ^ op_b;
            end
            rv_pkg::ALU_SRL: begin
                alu_res = op_a >> shamt;
            end
            rv_pkg::ALU_SRA: begin
                alu_res = rv_pkg::xlen_t'($signed(op_a) >>> shamt);     // Sign bit fills in
            end
            rv_pkg::ALU_OR: begin
                alu_res = op_a | op_b;
            end
            rv_pkg::ALU_AND: begin
                alu_res = op_a & op_b;
            end
            rv_pkg::ALU_PASS_B: begin
                alu_res = op_b;                       // LUI result is the U immediate
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= decoded.valid;                // One cycle after decode
        end
    end

    always_ff @(posedge clk) begin
        if (decoded.valid) begin
            wb_rd   <= decoded.rd;                    // Result and target move together
            wb_data <= alu_res;
        end
    end

endmodule

`default_nettype wire

// File: rv_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top #(
    parameter int NUM_REGS = 32                       // Set to 16 for RV32E
) (
    input  wire               clk,
    input  wire               rst,
    input  logic              instr_valid,
    input  rv_pkg::instr_t    instr,
    output logic              illegal,                // One cycle after instr_valid
    output logic              wb_valid,               // Two cycles after instr_valid
    output rv_pkg::reg_idx_t  wb_rd,
    output rv_pkg::xlen_t     wb_data
);

    rv_pkg::reg_idx_t rs1, rs2;                       // Read addresses from execute
    rv_pkg::xlen_t    rs1_data, rs2_data;

    decode_if i_decode_if ();

    control_unit #(
        .NUM_REGS    (NUM_REGS)
    ) i_control_unit (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .illegal     (illegal),
        .decoded     (i_decode_if.decoder)
    );

    register_file #(
        .NUM_REGS    (NUM_REGS)
    ) i_register_file (
        .clk         (clk),
        .rst         (rst),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .wr_en       (wb_valid),                      // Write-back output doubles as write port
        .wr_rd       (wb_rd),
        .wr_data     (wb_data)
    );

    execute_unit i_execute_unit (
        .clk         (clk),
        .rst         (rst),
        .decoded     (i_decode_if.execute),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

endmodule

`default_nettype wire

// File: tb_rv_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec;

    localparam int CLK_PERIOD = 4;                    // ns
    localparam int NUM_CLEAR  = 8;                    // ADDs on the cleared register file
    localparam int NUM_SEED   = 62;                   // LUI plus ADDI for x1..x31
    localparam int NUM_RANDOM = 300;
    localparam int NUM_CHAIN  = 20;
    localparam int NUM_INSTR  = NUM_CLEAR + NUM_SEED + NUM_RANDOM + NUM_CHAIN;

    logic             clk = 1'b0;
    logic             rst;
    logic             instr_valid;
    rv_pkg::instr_t   instr;
    logic             illegal;
    logic             wb_valid;
    rv_pkg::reg_idx_t wb_rd;
    rv_pkg::xlen_t    wb_data;

    logic [31:0]      lfsr = 32'h4f64;                // Galois LFSR state
    int               cyc = 0;                        // Rising edges seen so far
    rv_pkg::xlen_t    model_regs [32];                // Architectural state of the model
    rv_pkg::pc_t      model_pc;
    int               wb_due [$];                     // Cycle in which each write-back is due
    rv_pkg::reg_idx_t wb_rd_q [$];
    rv_pkg::xlen_t    wb_data_q [$];
    int               ill_due [$];                    // Cycle in which each illegal is due

    rv_exec_top #(
        .NUM_REGS    (32)
    ) i_rv_exec_top (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .illegal     (illegal),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // One LFSR step per bit taken, bits collected MSB first
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input rv_pkg::xlen_t got,
                              input rv_pkg::xlen_t want);
        if (got !== want) begin
            abort_run($sformatf("ERROR at %0t: %s got %h expected %h", $time, name, got, want));
        end
    endtask

    task automatic check_rd(input string name, input rv_pkg::reg_idx_t got,
                            input rv_pkg::reg_idx_t want);
        if (got !== want) begin
            abort_run($sformatf("ERROR at %0t: %s got %0d expected %0d", $time, name, got, want));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want && want) begin
            abort_run($sformatf("At %0t the %s strobe was due but did not come", $time, name));
        end else if (got !== want) begin
            abort_run($sformatf("At %0t the %s strobe came with nothing due", $time, name));
        end
    endtask

    // Expected result of one word from the RV32I rules
    function automatic rv_pkg::xlen_t predict_result(input rv_pkg::xlen_t regs [32],
                                                     input rv_pkg::pc_t pc,
                                                     input rv_pkg::instr_t w,
                                                     output logic bad);
        rv_pkg::xlen_t a, b, r;
        rv_pkg::xlen_t imm_u;
        logic [2:0]    f3;
        logic [6:0]    f7;
        logic          op_r, alt;
        a     = regs[w[19:15]];
        b     = regs[w[24:20]];
        imm_u = {w[31:12], 12'h000};
        f3    = w[14:12];
        f7    = w[31:25];
        op_r  = (w[6:0] == rv_pkg::OPC_OP);
        alt   = (f7 == rv_pkg::F7_ALT);
        bad   = 1'b0;
        r     = '0;
        if (w[6:0] == rv_pkg::OPC_LUI) begin
            r = imm_u;
        end else if (w[6:0] == rv_pkg::OPC_AUIPC) begin
            r = pc + imm_u;                           // Address of this very word
        end else if (op_r || w[6:0] == rv_pkg::OPC_OP_IMM) begin
            if (!op_r) begin
                b = {{20{w[31]}}, w[31:20]};          // shamt sits in the low 5 bits
            end
            if (op_r) begin
                bad = !(f7 == rv_pkg::F7_BASE ||
                        (alt && (f3 == rv_pkg::F3_ADD_SUB || f3 == rv_pkg::F3_SRL_SRA)));
            end else if (f3 == rv_pkg::F3_SLL) begin
                bad = (f7 != rv_pkg::F7_BASE);
            end else if (f3 == rv_pkg::F3_SRL_SRA) begin
                bad = !(f7 == rv_pkg::F7_BASE || alt);
            end
            case (f3)
                rv_pkg::F3_ADD_SUB: r = (op_r && alt) ? a - b : a + b;
                rv_pkg::F3_SLL:     r = a << b[4:0];
                rv_pkg::F3_SLT:     r = {31'b0, $signed(a) < $signed(b)};
                rv_pkg::F3_SLTU:    r = {31'b0, a < b};
                rv_pkg::F3_XOR:     r = a ^ b;
                rv_pkg::F3_SRL_SRA: r = alt ? rv_pkg::xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                rv_pkg::F3_OR:      r = a | b;
                default:            r = a & b;
            endcase
        end else begin
            bad = 1'b1;                               // Opcode outside the slice
        end
        return r;
    endfunction

    function automatic rv_pkg::instr_t op_imm_word(input rv_pkg::reg_idx_t rd,
                                                   input rv_pkg::reg_idx_t rs1);
        logic [31:0] f3, imm, pick;
        f3   = rand_bits(3);
        imm  = rand_bits(12);
        pick = rand_bits(1);
        if (f3[2:0] == rv_pkg::F3_SLL) begin
            imm[11:5] = rv_pkg::F7_BASE;
        end else if (f3[2:0] == rv_pkg::F3_SRL_SRA) begin
            imm[11:5] = pick[0] ? rv_pkg::F7_ALT : rv_pkg::F7_BASE;    // SRAI or SRLI
        end
        return {imm[11:0], rs1, f3[2:0], rd, rv_pkg::OPC_OP_IMM};
    endfunction

    function automatic rv_pkg::instr_t op_word(input rv_pkg::reg_idx_t rd,
                                               input rv_pkg::reg_idx_t rs1,
                                               input rv_pkg::reg_idx_t rs2);
        logic [31:0] f3, pick;
        logic [6:0]  f7;
        f3   = rand_bits(3);
        pick = rand_bits(1);
        f7   = rv_pkg::F7_BASE;
        if (pick[0] && (f3[2:0] == rv_pkg::F3_ADD_SUB || f3[2:0] == rv_pkg::F3_SRL_SRA)) begin
            f7 = rv_pkg::F7_ALT;                      // SUB or SRA
        end
        return {f7, rs2, rs1, f3[2:0], rd, rv_pkg::OPC_OP};
    endfunction

    function automatic rv_pkg::instr_t random_instr();
        logic [31:0]    kind, rd, rs1, rs2, extra;
        rv_pkg::instr_t w;
        kind  = rand_bits(4);
        rd    = rand_bits(5);
        rs1   = rand_bits(5);
        rs2   = rand_bits(5);
        case (kind[3:0])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4: w = op_imm_word(rd[4:0], rs1[4:0]);
            4'd10: begin
                extra = rand_bits(20);
                w = {extra[19:0], rd[4:0], rv_pkg::OPC_LUI};
            end
            4'd11: begin
                extra = rand_bits(20);
                w = {extra[19:0], rd[4:0], rv_pkg::OPC_AUIPC};
            end
            4'd12: begin
                extra = rand_bits(5);
                w = op_word(rd[4:0], rs1[4:0], rs2[4:0]);
                w[6:0] = {extra[4:0], 2'b11};
                if (w[6:0] == rv_pkg::OPC_OP_IMM || w[6:0] == rv_pkg::OPC_OP ||
                    w[6:0] == rv_pkg::OPC_LUI || w[6:0] == rv_pkg::OPC_AUIPC) begin
                    w[3] = ~w[3];                     // Move off a supported opcode
                end
            end
            4'd13: begin
                extra = rand_bits(7);
                w = op_word(rd[4:0], rs1[4:0], rs2[4:0]);
                w[31:25] = extra[6:0] | 7'h01;        // Neither base nor alternate funct7
            end
            4'd14: w = op_imm_word(5'd0, rs1[4:0]);   // Write aimed at x0
            default: w = op_word(rd[4:0], rs1[4:0], rs2[4:0]);
        endcase
        return w;
    endfunction

    task automatic issue(input rv_pkg::instr_t w);
        rv_pkg::xlen_t want;
        logic          bad;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w;
        want = predict_result(model_regs, model_pc, w, bad);
        if (bad) begin
            ill_due.push_back(cyc + 2);               // cyc still holds the pre-edge count
        end else begin
            wb_due.push_back(cyc + 3);
            wb_rd_q.push_back(w[11:7]);
            wb_data_q.push_back(want);
            if (w[11:7] != 5'd0) begin
                model_regs[w[11:7]] = want;
            end
            model_pc = model_pc + 32'd4;              // Only accepted words advance it
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    task automatic random_gap();
        logic [31:0] g;
        g = rand_bits(2);
        if (g == 32'd0) begin
            g = rand_bits(2);
            idle(1 + int'(g[0]) + int'(g[1]));        // 1 to 3 idle cycles
        end
    endtask

    // Outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        logic exp_wb, exp_ill;
        if (!rst) begin
            exp_wb  = (wb_due.size() != 0) && (wb_due[0] == cyc);
            exp_ill = (ill_due.size() != 0) && (ill_due[0] == cyc);
            check_flag("wb_valid", wb_valid, exp_wb);
            check_flag("illegal", illegal, exp_ill);
            if (exp_wb) begin
                check_rd("wb_rd", wb_rd, wb_rd_q.pop_front());
                check_data("wb_data", wb_data, wb_data_q.pop_front());
                void'(wb_due.pop_front());
            end
            if (exp_ill) begin
                void'(ill_due.pop_front());
            end
        end
    end

    initial begin
        #((NUM_INSTR * 4 + 100) * CLK_PERIOD);
        abort_run("Watchdog timeout, the run did not reach its end in time");
    end

    initial begin
        logic [31:0]      up, lo, rd, rs, pick;
        rv_pkg::reg_idx_t prev;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        model_pc    = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < NUM_CLEAR; i++) begin    // Every register reads 0 here
            rd = rand_bits(5);
            rs = rand_bits(10);
            issue({rv_pkg::F7_BASE, rs[9:5], rs[4:0], rv_pkg::F3_ADD_SUB, rd[4:0], rv_pkg::OPC_OP});
        end

        for (int r = 1; r < 32; r++) begin            // LUI then dependent ADDI
            up = rand_bits(20);
            lo = rand_bits(12);
            issue({up[19:0], 5'(r), rv_pkg::OPC_LUI});
            issue({lo[11:0], 5'(r), rv_pkg::F3_ADD_SUB, 5'(r), rv_pkg::OPC_OP_IMM});
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            issue(random_instr());
            random_gap();
        end

        prev = 5'd1;
        for (int i = 0; i < NUM_CHAIN; i++) begin     // Each one reads the previous rd
            rd   = rand_bits(5) | 32'd1;
            rs   = rand_bits(5);
            pick = rand_bits(1);
            issue(pick[0] ? op_word(rd[4:0], prev, rs[4:0]) : op_imm_word(rd[4:0], prev));
            prev = rd[4:0];
        end

        idle(1);
        while (wb_due.size() != 0 || ill_due.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);                    // Room for a stray strobe to show
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
rv_pkg.sv
decode_if.sv
control_unit.sv
register_file.sv
execute_unit.sv
rv_exec_top.sv
tb_rv_exec.sv

// File: Makefile
TOP := tb_rv_exec
SRCS := rv_pkg.sv decode_if.sv control_unit.sv register_file.sv execute_unit.sv rv_exec_top.sv

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f $(SRCS) tb_rv_exec.sv
	verilator --binary -j 0 -Wno-fatal --top-module $(TOP) -f project.f -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall -Wno-fatal --top-module rv_exec_top $(SRCS)

clean:
	rm -rf obj_dir
